/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f compile.f --top-module xtea_tb -Mdir obj_dir
	./obj_dir/Vxtea_tb

clean:
	rm -rf obj_dir

/* compile.f */
+incdir+verilog
verilog/xtea_pkg.sv
verilog/xtea_apb_regs.sv
verilog/xtea_block_buf.sv
verilog/xtea_fsm.sv
verilog/xtea_round_counter.sv
verilog/xtea_engine.sv
verilog/xtea_top.sv
testbench/xtea_asserts.sv
testbench/xtea_tb.sv

/* testbench/xtea_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module xtea_asserts (
  input logic                   clk,
  input logic                   reset_n,
  input xtea_pkg::apb_req_t     apb_req_i,
  input xtea_pkg::apb_rsp_t     apb_rsp_i,
  input logic                   busy_i,
  input xtea_pkg::engine_ctrl_t eng_ctrl_i,
  input logic                   eng_busy_i,
  input logic                   buf_we_i
);

  // Zero wait state slave
  pready_in_access: assert property (@(posedge clk) disable iff (!reset_n)
    (apb_req_i.psel && apb_req_i.penable) |-> apb_rsp_i.pready)
    else $error("pready low in an APB access phase");

  // Engine stays idle while the FSM sits in IDLE
  quiet_when_idle: assert property (@(posedge clk) disable iff (!reset_n)
    !busy_i |-> !eng_busy_i)
    else $error("engine busy while the FSM is idle");

  // One start pulse, and the engine picks it up
  start_one_cycle: assert property (@(posedge clk) disable iff (!reset_n)
    eng_ctrl_i.start |=> (!eng_ctrl_i.start && eng_busy_i))
    else $error("engine start held too long or not taken by the engine");

  no_buf_write_busy: assert property (@(posedge clk) disable iff (!reset_n)
    busy_i |-> !buf_we_i)
    else $error("APB buffer write accepted while busy");

endmodule

bind xtea_top xtea_asserts u_asserts (
  .clk        (clk),
  .reset_n    (reset_n),
  .apb_req_i  (apb_i),
  .apb_rsp_i  (apb_o),
  .busy_i     (busy),
  .eng_ctrl_i (eng_ctrl),
  .eng_busy_i (eng_flags.busy),
  .buf_we_i   (buf_we)
);

`default_nettype wire

/* testbench/xtea_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "xtea_defs.svh"

module xtea_tb;

  // Blocks run by all tests together, and APB transfers including status polls
  localparam int JOB_BLOCKS      = 16;
  localparam int APB_XFERS       = 450;
  localparam int WATCHDOG_CYCLES = 2 * (JOB_BLOCKS * 35 + APB_XFERS * 3);

  logic               clk;
  logic               reset_n;
  xtea_pkg::apb_req_t apb_req;
  xtea_pkg::apb_rsp_t apb_rsp;

  integer           seed;
  string            test_name;
  logic [3:0][31:0] tb_key;
  logic [63:0]      mem_model [16];
  logic [63:0]      plain [16];

  xtea_top UUT (
    .clk     (clk),
    .reset_n (reset_n),
    .apb_i   (apb_req),
    .apb_o   (apb_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Reference XTEA, k[0] is the word at KEY0 and v0 the upper half
  function automatic logic [63:0] xtea_model(input logic [63:0] blk,
                                             input logic [3:0][31:0] k,
                                             input logic dec);
    logic [31:0] v0;
    logic [31:0] v1;
    logic [31:0] sum;
    v0  = blk[63:32];
    v1  = blk[31:0];
    sum = dec ? 32'(`XTEA_DELTA * `XTEA_ROUNDS) : 32'd0;
    for (int n = 0; n < `XTEA_ROUNDS; n++) begin
      if (!dec) begin
        v0  = v0 + ((((v1 << 4) ^ (v1 >> 5)) + v1) ^ (sum + k[sum[1:0]]));
        sum = sum + `XTEA_DELTA;
        v1  = v1 + ((((v0 << 4) ^ (v0 >> 5)) + v0) ^ (sum + k[sum[12:11]]));
      end else begin
        v1  = v1 - ((((v0 << 4) ^ (v0 >> 5)) + v0) ^ (sum + k[sum[12:11]]));
        sum = sum - `XTEA_DELTA;
        v0  = v0 - ((((v1 << 4) ^ (v1 >> 5)) + v1) ^ (sum + k[sum[1:0]]));
      end
    end
    return {v0, v1};
  endfunction

  function automatic logic [63:0] rand64();
    return {32'($random(seed)), 32'($random(seed))};
  endfunction

  task automatic abort_run();
    $display("TB FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check(input string label, input logic [63:0] expected,
                       input logic [63:0] actual);
    if (actual !== expected) begin
      $display("FAIL %s (%s): expected %h, actual %h", test_name, label, expected, actual);
      abort_run();
    end
  endtask

  // Setup, access, then sample the response mid-cycle in the access phase
  task automatic apb_xfer(input logic write, input logic [11:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output logic slverr);
    @(posedge clk);
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= write;
    apb_req.paddr   <= addr;
    apb_req.pwdata  <= wdata;
    @(posedge clk);
    apb_req.penable <= 1'b1;
    @(negedge clk);
    rdata  = apb_rsp.prdata;
    slverr = apb_rsp.pslverr;
    check("pready in access phase", 64'd1, 64'(apb_rsp.pready));
    @(posedge clk);
    apb_req <= '0;
  endtask

  task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    logic        err;
    apb_xfer(1'b1, addr, data, rd, err);
    check($sformatf("pslverr on write to %h", addr), 64'd0, 64'(err));
  endtask

  task automatic apb_write_refused(input logic [11:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    logic        err;
    apb_xfer(1'b1, addr, data, rd, err);
    check($sformatf("pslverr on write to %h", addr), 64'd1, 64'(err));
  endtask

  task automatic apb_read(input logic [11:0] addr, output logic [31:0] data);
    logic err;
    apb_xfer(1'b0, addr, 32'd0, data, err);
    check($sformatf("pslverr on read of %h", addr), 64'd0, 64'(err));
  endtask

  task automatic write_block(input int idx, input logic [63:0] blk);
    apb_write(12'(`XTEA_BUF_WINDOW + idx * 8), blk[63:32]);
    apb_write(12'(`XTEA_BUF_WINDOW + idx * 8 + 4), blk[31:0]);
  endtask

  task automatic read_block(input int idx, output logic [63:0] blk);
    logic [31:0] hi;
    logic [31:0] lo;
    apb_read(12'(`XTEA_BUF_WINDOW + idx * 8), hi);
    apb_read(12'(`XTEA_BUF_WINDOW + idx * 8 + 4), lo);
    blk = {hi, lo};
  endtask

  task automatic load_key();
    for (int k = 0; k < 4; k++) begin
      apb_write(12'(`XTEA_REG_KEY0 + k * 4), tb_key[k]);
    end
  endtask

  // Expected buffer image after a job
  task automatic apply_model(input int base, input int count, input logic dec);
    for (int i = base; i < base + count; i++) begin
      mem_model[i] = xtea_model(mem_model[i], tb_key, dec);
    end
  endtask

  // Poll STATUS until done is set and busy has fallen
  task automatic wait_done(input int blocks);
    logic [31:0] status;
    int          cycles;
    status = 32'd0;
    cycles = 0;
    while (!(status[1] && !status[0])) begin
      if (cycles > blocks * 35 + 40) begin
        $display("ERROR: %s: job of %0d blocks did not finish", test_name, blocks);
        abort_run();
      end else begin
        apb_read(`XTEA_REG_STATUS, status);
        cycles += 3;
      end
    end
  endtask

  task automatic run_job(input int base, input int count, input logic dec);
    apb_write(`XTEA_REG_BASE, 32'(base));
    apb_write(`XTEA_REG_COUNT, 32'(count));
    apb_write(`XTEA_REG_CTRL, {30'd0, dec, 1'b1});
    wait_done(count);
    apply_model(base, count, dec);
  endtask

  task automatic reset_and_registers();
    logic [31:0] rd;
    test_name = "reset_regs";
    apb_read(`XTEA_REG_STATUS, rd);
    check("status after reset", 64'd0, 64'(rd));
    for (int k = 0; k < 4; k++) begin
      tb_key[k] = 32'($random(seed));
    end
    load_key();
    for (int k = 0; k < 4; k++) begin
      apb_read(12'(`XTEA_REG_KEY0 + k * 4), rd);
      check($sformatf("key word %0d", k), 64'(tb_key[k]), 64'(rd));
    end
    apb_write(`XTEA_REG_BASE, 32'd5);
    apb_write(`XTEA_REG_COUNT, 32'd7);
    apb_read(`XTEA_REG_BASE, rd);
    check("base readback", 64'd5, 64'(rd));
    apb_read(`XTEA_REG_COUNT, rd);
    check("count readback", 64'd7, 64'(rd));
  endtask

  task automatic single_block_encrypt();
    logic [63:0] blk;
    test_name = "single_block";
    // Published vector for an all-zero key and block
    tb_key = '0;
    load_key();
    mem_model[0] = 64'd0;
    write_block(0, 64'd0);
    run_job(0, 1, 1'b0);
    read_block(0, blk);
    check("zero key vector", 64'hdee9d4d8_f7131ed9, blk);
    check("model on zero key vector", 64'hdee9d4d8_f7131ed9, mem_model[0]);
    tb_key = {32'($random(seed)), 32'($random(seed)), 32'($random(seed)), 32'($random(seed))};
    load_key();
    mem_model[9] = rand64();
    write_block(9, mem_model[9]);
    run_job(9, 1, 1'b0);
    read_block(9, blk);
    check("random block", mem_model[9], blk);
  endtask

  task automatic multi_block_job();
    logic [63:0] blk;
    logic [31:0] rd;
    test_name = "multi_block";
    tb_key = {32'($random(seed)), 32'($random(seed)), 32'($random(seed)), 32'($random(seed))};
    load_key();
    for (int i = 0; i < 16; i++) begin
      plain[i]     = rand64();
      mem_model[i] = plain[i];
      write_block(i, plain[i]);
    end
    run_job(3, 5, 1'b0);
    // Blocks outside 3 to 7 keep their plaintext in the model
    for (int i = 0; i < 16; i++) begin
      read_block(i, blk);
      check($sformatf("block %0d", i), mem_model[i], blk);
    end
    apb_read(`XTEA_REG_STATUS, rd);
    check("status after job", 64'd2, 64'(rd));
  endtask

  task automatic decrypt_round_trip();
    logic [63:0] blk;
    test_name = "round_trip";
    run_job(3, 5, 1'b1);
    for (int i = 0; i < 16; i++) begin
      read_block(i, blk);
      check($sformatf("block %0d", i), plain[i], blk);
    end
  endtask

  task automatic error_responses();
    logic [31:0] rd;
    logic [63:0] blk;
    test_name = "error_responses";
    apb_write_refused(12'h020, 32'h1);
    apb_read(`XTEA_REG_KEY0, rd);
    check("key after unmapped write", 64'(tb_key[0]), 64'(rd));
    // Empty job
    apb_write(`XTEA_REG_COUNT, 32'd0);
    apb_write_refused(`XTEA_REG_CTRL, 32'd1);
    apb_read(`XTEA_REG_STATUS, rd);
    check("busy after empty start", 64'd0, 64'(rd[0]));
    // Job running past the end of the buffer
    apb_write(`XTEA_REG_BASE, 32'd12);
    apb_write(`XTEA_REG_COUNT, 32'd5);
    apb_write_refused(`XTEA_REG_CTRL, 32'd1);
    apb_read(`XTEA_REG_STATUS, rd);
    check("busy after oversized start", 64'd0, 64'(rd[0]));
    apb_read(`XTEA_REG_BASE, rd);
    check("base after oversized start", 64'd12, 64'(rd));
    apb_read(`XTEA_REG_COUNT, rd);
    check("count after oversized start", 64'd5, 64'(rd));
    // Writes while a four block job runs
    apb_write(`XTEA_REG_BASE, 32'd0);
    apb_write(`XTEA_REG_COUNT, 32'd4);
    apb_write(`XTEA_REG_CTRL, 32'd1);
    apb_write_refused(`XTEA_BUF_WINDOW, 32'hdeadbeef);
    apb_write_refused(`XTEA_REG_BASE, 32'd9);
    wait_done(4);
    apply_model(0, 4, 1'b0);
    apb_read(`XTEA_REG_BASE, rd);
    check("base after busy write", 64'd0, 64'(rd));
    for (int i = 0; i < 4; i++) begin
      read_block(i, blk);
      check($sformatf("block %0d", i), mem_model[i], blk);
    end
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES + 5) @(posedge clk);
    $display("ERROR: watchdog expired after %0d cycles, tests did not complete",
             WATCHDOG_CYCLES);
    abort_run();
  end

  initial begin
    seed = 32'hbd6baa42;
    reset_n <= 1'b0;
    apb_req <= '0;
    repeat (5) @(posedge clk);
    reset_n <= 1'b1;
    reset_and_registers();
    single_block_encrypt();
    multi_block_job();
    decrypt_round_trip();
    error_responses();
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/xtea_apb_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "xtea_defs.svh"

module xtea_apb_regs (
  input  logic                 clk,
  input  logic                 reset_n,
  input  xtea_pkg::apb_req_t   apb_i,
  output xtea_pkg::apb_rsp_t   apb_o,
  output xtea_pkg::xtea_cfg_t  cfg_o,
  output logic                 start_o,
  input  logic                 busy_i,
  input  logic                 done_i,
  output logic                 buf_we_o,
  output logic                 buf_re_o,
  output logic [4:0]           buf_addr_o,
  output logic [31:0]          buf_wdata_o,
  input  logic [31:0]          buf_rdata_i
);

  logic [3:0][31:0] key_q;
  logic [3:0]       base_q;
  logic [4:0]       count_q;
  logic             decrypt_q;
  logic             done_q;

  logic        setup;
  logic        access;
  logic        wr;
  logic        wr_ok;
  logic [11:0] win_off;
  logic        in_win;
  logic        is_ctrl, is_status, is_key, is_base, is_count;
  logic [1:0]  key_sel;
  logic [5:0]  span;
  logic        unmapped, busy_wr, bad_start, err;
  logic [31:0] rdata;

  assign setup   = apb_i.psel & ~apb_i.penable;
  assign access  = apb_i.psel & apb_i.penable;
  assign wr      = access & apb_i.pwrite;
  assign win_off = apb_i.paddr - `XTEA_BUF_WINDOW;
  assign in_win  = (apb_i.paddr >= `XTEA_BUF_WINDOW) &&
                   (win_off < 12'(8 * `XTEA_BUF_DEPTH));

  // Register decode and read mux
  always_comb begin
    is_ctrl   = 1'b0;
    is_status = 1'b0;
    is_key    = 1'b0;
    is_base   = 1'b0;
    is_count  = 1'b0;
    key_sel   = 2'd0;
    rdata     = buf_rdata_i;
    case (apb_i.paddr)
      `XTEA_REG_CTRL: begin
        is_ctrl = 1'b1;
        rdata   = {30'd0, decrypt_q, 1'b0};
      end
      `XTEA_REG_STATUS: begin
        is_status = 1'b1;
        rdata     = {30'd0, done_q, busy_i};
      end
      `XTEA_REG_KEY0, `XTEA_REG_KEY1, `XTEA_REG_KEY2, `XTEA_REG_KEY3: begin
        is_key  = 1'b1;
        key_sel = 2'((apb_i.paddr - `XTEA_REG_KEY0) >> 2);
        rdata   = key_q[key_sel];
      end
      `XTEA_REG_BASE: begin
        is_base = 1'b1;
        rdata   = {28'd0, base_q};
      end
      `XTEA_REG_COUNT: begin
        is_count = 1'b1;
        rdata    = {27'd0, count_q};
      end
      default: ;
    endcase
  end

  // Start is legal only for a non-empty job that fits in the buffer
  assign span      = {2'b00, base_q} + {1'b0, count_q};
  assign unmapped  = ~(is_ctrl | is_status | is_key | is_base | is_count | in_win);
  assign busy_wr   = wr & busy_i & (is_ctrl | is_key | is_base | is_count | in_win);
  assign bad_start = wr & is_ctrl & apb_i.pwdata[0] &
                     ((count_q == 5'd0) || (span > 6'(`XTEA_BUF_DEPTH)));
  assign err       = access & (unmapped | busy_wr | bad_start);
  assign wr_ok     = wr & ~err;

  assign start_o = wr_ok & is_ctrl & apb_i.pwdata[0];

  // Buffer window passes through as 32-bit half accesses
  assign buf_re_o    = setup & ~apb_i.pwrite & in_win;
  assign buf_we_o    = wr_ok & in_win;
  assign buf_addr_o  = win_off[6:2];
  assign buf_wdata_o = apb_i.pwdata;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      key_q     <= '0;
      base_q    <= '0;
      count_q   <= '0;
      decrypt_q <= 1'b0;
      done_q    <= 1'b0;
    end else begin
      if (wr_ok && is_key)   key_q[key_sel] <= apb_i.pwdata;
      if (wr_ok && is_base)  base_q         <= apb_i.pwdata[3:0];
      if (wr_ok && is_count) count_q        <= apb_i.pwdata[4:0];
      if (wr_ok && is_ctrl)  decrypt_q      <= apb_i.pwdata[1];
      // Sticky done, cleared by the next start
      if (start_o) begin
        done_q <= 1'b0;
      end else if (done_i) begin
        done_q <= 1'b1;
      end
    end
  end

  assign apb_o.prdata  = rdata;
  assign apb_o.pready  = 1'b1;
  assign apb_o.pslverr = err;

  assign cfg_o.key     = key_q;
  assign cfg_o.base    = base_q;
  assign cfg_o.count   = count_q;
  assign cfg_o.decrypt = decrypt_q;

endmodule

`default_nettype wire

/* verilog/xtea_block_buf.sv */
`timescale 1ns/1ps
`default_nettype none

`include "xtea_defs.svh"

module xtea_block_buf (
  input  logic                     clk,
  input  logic                     apb_we_i,
  input  logic                     apb_re_i,
  input  logic [4:0]               apb_addr_i,
  input  logic [31:0]              apb_wdata_i,
  output logic [31:0]              apb_rdata_o,
  input  xtea_pkg::buf_core_port_t core_i,
  output xtea_pkg::xtea_block_u    core_rdata_o
);

  xtea_pkg::xtea_block_u mem [`XTEA_BUF_DEPTH];

  logic [3:0] apb_blk;
  logic       apb_hi;

  // Odd half index selects v1
  assign apb_blk = apb_addr_i[4:1];
  assign apb_hi  = apb_addr_i[0];

  always_ff @(posedge clk) begin
    if (apb_we_i) begin
      if (apb_hi) begin
        mem[apb_blk].halves.v1 <= apb_wdata_i;
      end else begin
        mem[apb_blk].halves.v0 <= apb_wdata_i;
      end
    end
    if (core_i.we) begin
      mem[core_i.addr].raw <= core_i.wdata.raw;
    end
  end

  // Registered reads on both ports
  always_ff @(posedge clk) begin
    if (apb_re_i) begin
      apb_rdata_o <= apb_hi ? mem[apb_blk].halves.v1 : mem[apb_blk].halves.v0;
    end
    if (core_i.re) begin
      core_rdata_o.raw <= mem[core_i.addr].raw;
    end
  end

endmodule

`default_nettype wire

/* verilog/xtea_defs.svh */
`ifndef XTEA_DEFS_SVH
`define XTEA_DEFS_SVH

// XTEA cycles per block and key schedule constant
`define XTEA_ROUNDS      32
`define XTEA_DELTA       32'h9E3779B9

// Number of 64-bit blocks held in the local buffer
`define XTEA_BUF_DEPTH   16

// APB register byte offsets
`define XTEA_REG_CTRL    12'h000
`define XTEA_REG_STATUS  12'h004
`define XTEA_REG_KEY0    12'h008
`define XTEA_REG_KEY1    12'h00C
`define XTEA_REG_KEY2    12'h010
`define XTEA_REG_KEY3    12'h014
`define XTEA_REG_BASE    12'h018
`define XTEA_REG_COUNT   12'h01C

// Buffer window, two words per block, v0 at the lower address
`define XTEA_BUF_WINDOW  12'h100

`endif

/* verilog/xtea_engine.sv */
`timescale 1ns/1ps
`default_nettype none

`include "xtea_defs.svh"

module xtea_engine (
  input  logic                    clk,
  input  logic                    reset_n,
  input  xtea_pkg::engine_ctrl_t  ctrl_i,
  input  logic [3:0][31:0]        key_i,
  input  logic [4:0]              round_i,
  input  xtea_pkg::xtea_block_u   block_i,
  output xtea_pkg::xtea_block_u   block_o,
  output xtea_pkg::engine_flags_t flags_o
);

  // Sum after all rounds, starting point for decryption
  localparam logic [31:0] SUM_DEC = 32'(`XTEA_DELTA * `XTEA_ROUNDS);

  xtea_pkg::xtea_block_u blk_q;
  logic [31:0]           sum_q;
  logic                  busy_q;

  logic [31:0] v0_n, v1_n, sum_n;

  function automatic logic [31:0] mix(input logic [31:0] x);
    return ((x << 4) ^ (x >> 5)) + x;
  endfunction

  // One full cycle, two Feistel half-updates
  always_comb begin
    if (!ctrl_i.decrypt) begin
      v0_n  = blk_q.halves.v0 + (mix(blk_q.halves.v1) ^ (sum_q + key_i[sum_q[1:0]]));
      sum_n = sum_q + `XTEA_DELTA;
      v1_n  = blk_q.halves.v1 + (mix(v0_n) ^ (sum_n + key_i[sum_n[12:11]]));
    end else begin
      v1_n  = blk_q.halves.v1 - (mix(blk_q.halves.v0) ^ (sum_q + key_i[sum_q[12:11]]));
      sum_n = sum_q - `XTEA_DELTA;
      v0_n  = blk_q.halves.v0 - (mix(v1_n) ^ (sum_n + key_i[sum_n[1:0]]));
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl_i.start) begin
      blk_q <= block_i;
      sum_q <= ctrl_i.decrypt ? SUM_DEC : 32'd0;
    end else if (ctrl_i.enable) begin
      blk_q.halves.v0 <= v0_n;
      blk_q.halves.v1 <= v1_n;
      sum_q           <= sum_n;
    end
  end

  // Busy from start until the final round has been applied
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      busy_q <= 1'b0;
    end else if (ctrl_i.start) begin
      busy_q <= 1'b1;
    end else if (ctrl_i.enable && round_i == 5'(`XTEA_ROUNDS - 1)) begin
      busy_q <= 1'b0;
    end
  end

  assign block_o      = blk_q;
  assign flags_o.busy = busy_q;

endmodule

`default_nettype wire

/* verilog/xtea_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module xtea_fsm (
  input  logic                     clk,
  input  logic                     reset_n,
  input  logic                     start_i,
  input  xtea_pkg::xtea_cfg_t      cfg_i,
  input  xtea_pkg::xtea_block_u    block_i,
  output xtea_pkg::buf_core_port_t buf_o,
  output xtea_pkg::engine_ctrl_t   eng_o,
  output logic                     cnt_clear_o,
  output logic                     cnt_en_o,
  input  logic                     last_round_i,
  output logic                     busy_o,
  output logic                     done_o
);

  xtea_pkg::xtea_state_t state_q, state_d;

  logic [3:0] blk_q;
  logic [4:0] left_q;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state_q <= xtea_pkg::IDLE;
      blk_q   <= '0;
      left_q  <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == xtea_pkg::IDLE && start_i) begin
        blk_q  <= cfg_i.base;
        left_q <= cfg_i.count;
      end else if (state_q == xtea_pkg::STORE) begin
        blk_q  <= blk_q + 4'd1;
        left_q <= left_q - 5'd1;
      end
    end
  end

  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      xtea_pkg::IDLE: begin
        if (start_i) state_d = xtea_pkg::LOAD;
      end
      xtea_pkg::LOAD:  state_d = xtea_pkg::START;
      xtea_pkg::START: state_d = xtea_pkg::WORK;
      xtea_pkg::WORK: begin
        if (last_round_i) state_d = xtea_pkg::STORE;
      end
      xtea_pkg::STORE: begin
        // Last block done when only one was left
        state_d = (left_q == 5'd1) ? xtea_pkg::FINISHED : xtea_pkg::LOAD;
      end
      xtea_pkg::FINISHED: state_d = xtea_pkg::IDLE;
      default:            state_d = xtea_pkg::IDLE;
    endcase
  end

  // Buffer read in LOAD lands for START, result written back in STORE
  assign buf_o.re    = (state_q == xtea_pkg::LOAD);
  assign buf_o.we    = (state_q == xtea_pkg::STORE);
  assign buf_o.addr  = blk_q;
  assign buf_o.wdata = block_i;

  assign eng_o.start   = (state_q == xtea_pkg::START);
  assign eng_o.enable  = (state_q == xtea_pkg::WORK);
  assign eng_o.decrypt = cfg_i.decrypt;

  assign cnt_clear_o = (state_q == xtea_pkg::START);
  assign cnt_en_o    = (state_q == xtea_pkg::WORK);

  assign busy_o = (state_q != xtea_pkg::IDLE);
  assign done_o = (state_q == xtea_pkg::FINISHED);

endmodule

`default_nettype wire

/* verilog/xtea_pkg.sv */
`default_nettype none

package xtea_pkg;

  // APB request from the master
  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  // APB response to the master
  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  // Two halves of one block, v0 in the upper word
  typedef struct packed {
    logic [31:0] v0;
    logic [31:0] v1;
  } xtea_halves_t;

  // One cipher block, raw for storage or split for the datapath
  typedef union packed {
    logic [63:0]  raw;
    xtea_halves_t halves;
  } xtea_block_u;

  typedef struct packed {
    logic [3:0][31:0] key;
    logic [3:0]       base;
    logic [4:0]       count;
    logic             decrypt;
  } xtea_cfg_t;

  typedef struct packed {
    logic start;
    logic enable;
    logic decrypt;
  } engine_ctrl_t;

  typedef struct packed {
    logic busy;
  } engine_flags_t;

  // Core side of the block buffer
  typedef struct packed {
    logic        re;
    logic        we;
    logic [3:0]  addr;
    xtea_block_u wdata;
  } buf_core_port_t;

  typedef enum logic [2:0] {
    IDLE,
    LOAD,
    START,
    WORK,
    STORE,
    FINISHED
  } xtea_state_t;

endpackage

`default_nettype wire

/* verilog/xtea_round_counter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "xtea_defs.svh"

module xtea_round_counter (
  input  logic       clk,
  input  logic       reset_n,
  input  logic       clear_i,
  input  logic       en_i,
  output logic [4:0] round_o,
  output logic       last_round_o
);

  logic [4:0] round_q;

  // Wraps to zero after the final round
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      round_q <= '0;
    end else if (clear_i) begin
      round_q <= '0;
    end else if (en_i) begin
      round_q <= round_q + 5'd1;
    end
  end

  assign round_o      = round_q;
  assign last_round_o = (round_q == 5'(`XTEA_ROUNDS - 1));

endmodule

`default_nettype wire

/* verilog/xtea_top.sv */
`timescale 1ns/1ps
`default_nettype none

module xtea_top (
  input  logic               clk,
  input  logic               reset_n,
  input  xtea_pkg::apb_req_t apb_i,
  output xtea_pkg::apb_rsp_t apb_o
);

  xtea_pkg::xtea_cfg_t      cfg;
  xtea_pkg::buf_core_port_t buf_port;
  xtea_pkg::xtea_block_u    buf_block;
  xtea_pkg::xtea_block_u    eng_block;
  xtea_pkg::engine_ctrl_t   eng_ctrl;
  xtea_pkg::engine_flags_t  eng_flags;

  logic        start, busy, done;
  logic        buf_we, buf_re;
  logic [4:0]  buf_addr;
  logic [31:0] buf_wdata, buf_rdata;
  logic        cnt_clear, cnt_en, last_round;
  logic [4:0]  round;

  xtea_apb_regs i_regs (
    .clk         (clk),
    .reset_n     (reset_n),
    .apb_i       (apb_i),
    .apb_o       (apb_o),
    .cfg_o       (cfg),
    .start_o     (start),
    .busy_i      (busy),
    .done_i      (done),
    .buf_we_o    (buf_we),
    .buf_re_o    (buf_re),
    .buf_addr_o  (buf_addr),
    .buf_wdata_o (buf_wdata),
    .buf_rdata_i (buf_rdata)
  );

  xtea_block_buf i_buf (
    .clk          (clk),
    .apb_we_i     (buf_we),
    .apb_re_i     (buf_re),
    .apb_addr_i   (buf_addr),
    .apb_wdata_i  (buf_wdata),
    .apb_rdata_o  (buf_rdata),
    .core_i       (buf_port),
    .core_rdata_o (buf_block)
  );

  xtea_fsm i_fsm (
    .clk          (clk),
    .reset_n      (reset_n),
    .start_i      (start),
    .cfg_i        (cfg),
    .block_i      (eng_block),
    .buf_o        (buf_port),
    .eng_o        (eng_ctrl),
    .cnt_clear_o  (cnt_clear),
    .cnt_en_o     (cnt_en),
    .last_round_i (last_round),
    .busy_o       (busy),
    .done_o       (done)
  );

  xtea_round_counter i_counter (
    .clk          (clk),
    .reset_n      (reset_n),
    .clear_i      (cnt_clear),
    .en_i         (cnt_en),
    .round_o      (round),
    .last_round_o (last_round)
  );

  xtea_engine i_engine (
    .clk     (clk),
    .reset_n (reset_n),
    .ctrl_i  (eng_ctrl),
    .key_i   (cfg.key),
    .round_i (round),
    .block_i (buf_block),
    .block_o (eng_block),
    .flags_o (eng_flags)
  );

endmodule

`default_nettype wire
